// File: vlog.f
+incdir+hdl
hdl/core_pkg.sv
hdl/alu_issue_if.sv
hdl/instr_decode.sv
hdl/instr_queue.sv
hdl/reg_file.sv
hdl/issue_stage.sv
hdl/alu_stage.sv
hdl/int_core.sv
verification/int_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f vlog.f --top-module int_core_tb \
        -o int_core_sim \
    && ./obj_dir/int_core_sim | tee /dev/stderr | grep -q "TEST PASSED" \
    && exit 0 || exit 1

// File: verification/int_core_tb.sv
// testbench for int_core driving an instruction table over req/ack and checking writebacks
module int_core_tb import core_pkg::*; ();

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam int         NUM_RANDOM = 16;

    typedef struct packed {
        word_t    instr;
        logic     exp_wb;
        reg_idx_t rd;
        word_t    val;
    } entry_t;

    logic     clk;
    logic     rst;
    logic     instr_req;
    word_t    instr_data;
    logic     instr_ack;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    entry_t   tab[$];
    entry_t   exp_q[$];
    reg_idx_t rcv_rd[$];
    word_t    model_regs [32];
    logic [31:0] lcg_state;
    int       mismatches;
    int       pass_count;
    int       fail_count;
    int       cycles;
    int       cycle_limit;

    int_core u_dut (
        .clk        (clk),
        .rst        (rst),
        .instr_req  (instr_req),
        .instr_data (instr_data),
        .instr_ack  (instr_ack),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // queue one entry and update the model on every expected write
    task automatic add_entry(input word_t instr, input logic wb, input reg_idx_t rd,
                             input word_t val);
        entry_t e;
        e.instr  = instr;
        e.exp_wb = wb;
        e.rd     = rd;
        e.val    = val;
        tab.push_back(e);
        if (wb) begin
            model_regs[rd] = val;
        end
    endtask

    // random addi, add, xor or sub on registers the table has already written
    task automatic add_random_entry();
        logic [1:0]  op;
        logic [11:0] imm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        word_t       a;
        word_t       b;
        lcg_state = lcg_next(lcg_state);
        op  = lcg_state[29:28];
        rd  = reg_idx_t'((lcg_state[27:24] % 15) + 1);
        rs1 = reg_idx_t'((lcg_state[23:20] % 15) + 1);
        lcg_state = lcg_next(lcg_state);
        rs2 = reg_idx_t'((lcg_state[31:28] % 15) + 1);
        imm = lcg_state[27:16];
        a = model_regs[rs1];
        b = model_regs[rs2];
        case (op)
            2'd0: add_entry(enc_i(imm, rs1, 3'b000, rd, OPC_OP_IMM), 1'b1, rd,
                            a + {{20{imm[11]}}, imm});
            2'd1: add_entry(enc_r(7'h00, rs2, rs1, 3'b000, rd, OPC_OP), 1'b1, rd, a + b);
            2'd2: add_entry(enc_r(7'h00, rs2, rs1, 3'b100, rd, OPC_OP), 1'b1, rd, a ^ b);
            default: add_entry(enc_r(7'h20, rs2, rs1, 3'b000, rd, OPC_OP), 1'b1, rd, a - b);
        endcase
    endtask

    // four-phase handshake that starts and ends 1 unit after a rising edge
    task automatic send_instr(input word_t instr);
        instr_data = instr;
        instr_req  = 1'b1;
        @(posedge clk);
        #1;
        while (!instr_ack) begin
            @(posedge clk);
            #1;
        end
        instr_req = 1'b0;
        while (instr_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_wb_rd(input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("MISMATCH wb_rd got 0x%02h expected 0x%02h", got, exp);
            mismatches++;
        end
    endtask

    task automatic check_wb_data(input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH wb_data got 0x%08h expected 0x%08h", got, exp);
            mismatches++;
        end
    endtask

    // results are compared in program order as they leave the core
    always @(negedge clk) begin : monitor
        int idx;
        int prev_mismatches;
        if (!rst && wb_valid) begin
            rcv_rd.push_back(wb_rd);
            idx = rcv_rd.size() - 1;
            if (idx < exp_q.size()) begin
                prev_mismatches = mismatches;
                check_wb_rd(wb_rd, exp_q[idx].rd);
                check_wb_data(wb_data, exp_q[idx].val);
                if (mismatches == prev_mismatches) begin
                    pass_count++;
                    $display("result %0d x%0d = 0x%08h ok", idx, wb_rd, wb_data);
                end else begin
                    fail_count++;
                    $display("result %0d x%0d wrong", idx, exp_q[idx].rd);
                end
            end else begin
                fail_count++;
                $display("writeback to x%0d appeared with no instruction expecting one", wb_rd);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycle_limit == 0 || cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out waiting for a result after %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        instr_req   = 1'b0;
        instr_data  = '0;
        mismatches  = 0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_limit = 0;
        lcg_state   = 32'd64012;
        model_regs[0] = '0;

        // independent op-imm
        add_entry(enc_i(12'h123, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 1'b1, 5'd1, 32'h0000_0123);
        add_entry(enc_i(12'hffb, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), 1'b1, 5'd2, 32'hffff_fffb);
        add_entry(enc_i(12'h001, 5'd2, 3'b010, 5'd3, OPC_OP_IMM), 1'b1, 5'd3, 32'h0000_0001);
        add_entry(enc_i(12'h001, 5'd2, 3'b011, 5'd4, OPC_OP_IMM), 1'b1, 5'd4, 32'h0000_0000);
        add_entry(enc_i(12'h0f0, 5'd1, 3'b100, 5'd5, OPC_OP_IMM), 1'b1, 5'd5, 32'h0000_01d3);
        add_entry(enc_i(12'h700, 5'd1, 3'b110, 5'd6, OPC_OP_IMM), 1'b1, 5'd6, 32'h0000_0723);
        add_entry(enc_i(12'h0ff, 5'd2, 3'b111, 5'd7, OPC_OP_IMM), 1'b1, 5'd7, 32'h0000_00fb);
        add_entry(enc_i(12'h004, 5'd1, 3'b001, 5'd8, OPC_OP_IMM), 1'b1, 5'd8, 32'h0000_1230);
        add_entry(enc_i(12'h01c, 5'd2, 3'b101, 5'd9, OPC_OP_IMM), 1'b1, 5'd9, 32'h0000_000f);
        add_entry(enc_i(12'h401, 5'd2, 3'b101, 5'd10, OPC_OP_IMM), 1'b1, 5'd10, 32'hffff_fffd);
        // dependent chain through the scoreboard
        add_entry(enc_r(7'h00, 5'd6, 5'd1, 3'b000, 5'd11, OPC_OP), 1'b1, 5'd11, 32'h0000_0846);
        add_entry(enc_r(7'h20, 5'd1, 5'd11, 3'b000, 5'd12, OPC_OP), 1'b1, 5'd12, 32'h0000_0723);
        add_entry(enc_r(7'h00, 5'd3, 5'd12, 3'b001, 5'd13, OPC_OP), 1'b1, 5'd13, 32'h0000_0e46);
        add_entry(enc_r(7'h00, 5'd13, 5'd2, 3'b010, 5'd14, OPC_OP), 1'b1, 5'd14, 32'h0000_0001);
        add_entry(enc_r(7'h20, 5'd14, 5'd2, 3'b101, 5'd15, OPC_OP), 1'b1, 5'd15, 32'hffff_fffd);
        add_entry(enc_r(7'h00, 5'd14, 5'd15, 3'b101, 5'd16, OPC_OP), 1'b1, 5'd16, 32'h7fff_fffe);
        add_entry(enc_r(7'h00, 5'd15, 5'd16, 3'b011, 5'd17, OPC_OP), 1'b1, 5'd17, 32'h0000_0001);
        add_entry(enc_r(7'h00, 5'd16, 5'd17, 3'b100, 5'd18, OPC_OP), 1'b1, 5'd18, 32'h7fff_ffff);
        add_entry(enc_r(7'h00, 5'd8, 5'd18, 3'b110, 5'd19, OPC_OP), 1'b1, 5'd19, 32'h7fff_ffff);
        add_entry(enc_r(7'h00, 5'd12, 5'd19, 3'b111, 5'd20, OPC_OP), 1'b1, 5'd20, 32'h0000_0723);
        // lui and a dependent addi
        add_entry({20'habcde, 5'd21, OPC_LUI}, 1'b1, 5'd21, 32'habcd_e000);
        add_entry(enc_i(12'h7ff, 5'd21, 3'b000, 5'd22, OPC_OP_IMM), 1'b1, 5'd22, 32'habcd_e7ff);
        // acked but never written back
        add_entry(enc_i(12'h005, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 1'b0, 5'd0, '0);
        add_entry(32'h0000_0013, 1'b0, 5'd0, '0);
        add_entry(enc_i(12'h000, 5'd1, 3'b010, 5'd5, OPC_LOAD), 1'b0, 5'd0, '0);
        add_entry(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd8, OPC_BRANCH), 1'b0, 5'd0, '0);
        // x5 must still hold the xori result
        add_entry(enc_i(12'h001, 5'd5, 3'b000, 5'd23, OPC_OP_IMM), 1'b1, 5'd23, 32'h0000_01d4);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            add_random_entry();
        end
        cycle_limit = 20 * tab.size() + 50;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        #1;
        if (instr_ack !== 1'b0 || wb_valid !== 1'b0) begin
            fail_count++;
            $display("instr_ack or wb_valid is not low after reset");
        end
        @(posedge clk);
        #1;

        foreach (tab[i]) begin
            if (tab[i].exp_wb) begin
                exp_q.push_back(tab[i]);
            end
            send_instr(tab[i].instr);
        end
        while (rcv_rd.size() < exp_q.size()) begin
            @(posedge clk);
        end
        // leave room for any stray writeback
        repeat (10) @(posedge clk);
        if (rcv_rd.size() != exp_q.size()) begin
            fail_count++;
            $display("received %0d results but expected %0d", rcv_rd.size(), exp_q.size());
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/int_core.sv
// top level of the integer core, instruction handshake in and writeback results out
module int_core import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_req,
    input  word_t    instr_data,
    output logic     instr_ack,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    logic    push;
    logic    pop;
    logic    queue_full;
    logic    queue_empty;
    uop_t    dec_uop;
    uop_t    iq_head;
    wb_bus_t wb;

    alu_issue_if u_issue_if ();

    instr_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .instr_req  (instr_req),
        .instr_data (instr_data),
        .instr_ack  (instr_ack),
        .queue_full (queue_full),
        .push       (push),
        .uop        (dec_uop)
    );

    instr_queue u_queue (
        .clk   (clk),
        .rst   (rst),
        .push  (push),
        .pop   (pop),
        .din   (dec_uop),
        .dout  (iq_head),
        .empty (queue_empty),
        .full  (queue_full)
    );

    issue_stage u_issue (
        .clk   (clk),
        .rst   (rst),
        .head  (iq_head),
        .empty (queue_empty),
        .pop   (pop),
        .wb    (wb),
        .issue (u_issue_if.issue_mp)
    );

    alu_stage u_alu (
        .clk   (clk),
        .rst   (rst),
        .issue (u_issue_if.alu_mp),
        .wb    (wb)
    );

    // writeback bus split onto the top ports
    assign wb_valid = wb.has_rd;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.result;

endmodule

// File: hdl/alu_stage.sv
// alu execution stage, computes the issued operation and registers the writeback bus
module alu_stage import core_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    alu_issue_if.alu_mp   issue,
    output wb_bus_t       wb
);

    logic [4:0] shamt;
    word_t      alu_out;

    assign shamt = issue.opr2[4:0];

    always_comb begin
        case (issue.alufn)
            ALU_ADD:  alu_out = issue.opr1 + issue.opr2;
            ALU_SUB:  alu_out = issue.opr1 - issue.opr2;
            ALU_SLL:  alu_out = issue.opr1 << shamt;
            ALU_SLT:  alu_out = word_t'($signed(issue.opr1) < $signed(issue.opr2));
            ALU_SLTU: alu_out = word_t'(issue.opr1 < issue.opr2);
            ALU_XOR:  alu_out = issue.opr1 ^ issue.opr2;
            ALU_SRL:  alu_out = issue.opr1 >> shamt;
            ALU_SRA:  alu_out = word_t'($signed(issue.opr1) >>> shamt);
            ALU_OR:   alu_out = issue.opr1 | issue.opr2;
            ALU_AND:  alu_out = issue.opr1 & issue.opr2;
            default:  alu_out = '0;
        endcase
    end

    // every issued op has a nonzero rd, decode drops the rest
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.has_rd <= 1'b0;
        end else begin
            wb.has_rd <= issue.valid;
        end
        wb.rd     <= issue.rd;
        wb.result <= alu_out;
    end

endmodule

// File: hdl/issue_stage.sv
// issue stage, scoreboards the queue head, reads operands and loads the alu issue register
`include "core_defs.svh"

module issue_stage import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  uop_t                 head,
    input  logic                 empty,
    output logic                 pop,
    input  wb_bus_t              wb,
    alu_issue_if.issue_mp        issue
);

    logic [`NUM_REGS-1:0] busy;
    logic [`NUM_REGS-1:0] clr_mask;
    logic [`NUM_REGS-1:0] set_mask;
    logic [`NUM_REGS-1:0] busy_now;
    logic                 hazard;
    logic                 can_issue;
    word_t                rs1_data;
    word_t                rs2_data;
    word_t                opr1;
    word_t                opr2;

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (head.rs1),
        .rs2      (head.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    // a writeback this cycle already frees its register, the value comes
    // through the register file bypass
    assign clr_mask = wb.has_rd ? (`NUM_REGS'(1) << wb.rd) : '0;
    assign busy_now = busy & ~clr_mask;

    // rd is checked too so results retire in program order
    assign hazard = (head.has_rs1 & busy_now[head.rs1])
                  | (head.has_rs2 & busy_now[head.rs2])
                  | (head.has_rd  & busy_now[head.rd]);

    assign can_issue = ~empty & ~hazard;
    assign pop       = can_issue;

    assign set_mask = (can_issue && head.has_rd && head.rd != '0)
                    ? (`NUM_REGS'(1) << head.rd) : '0;

    // set wins over a clear of the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            busy <= busy_now | set_mask;
        end
    end

    // operand selection
    assign opr1 = head.is_lui ? '0 : rs1_data;
    assign opr2 = (head.opr2_sel == OPR2_IMM) ? head.imm : rs2_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= can_issue;
        end
        if (can_issue) begin
            issue.rd    <= head.rd;
            issue.alufn <= head.alufn;
            issue.opr1  <= opr1;
            issue.opr2  <= opr2;
        end
    end

endmodule

// File: hdl/reg_file.sv
// integer register file, two read ports and one write port fed by the writeback bus
`include "core_defs.svh"

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  wb_bus_t  wb
);

    word_t regs [`NUM_REGS];
    logic  wr_en;

    // x0 is never written
    assign wr_en = ~rst & wb.has_rd & (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // write-through, so a result is usable in the cycle it is written
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wr_en && wb.rd == rs1) ? wb.result : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wr_en && wb.rd == rs2) ? wb.result : regs[rs2];

endmodule

// File: hdl/instr_queue.sv
// show-ahead micro-op FIFO between decode and issue
`include "core_defs.svh"

module instr_queue import core_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    input  uop_t din,
    output uop_t dout,
    output logic empty,
    output logic full
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    uop_t             mem [`IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(`IQ_DEPTH));
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // head is visible without a read cycle
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/instr_decode.sv
// decode stage, accepts instructions over req/ack and pushes micro-ops into the queue
`include "core_defs.svh"

module instr_decode import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  instr_req,
    input  word_t instr_data,
    output logic  instr_ack,
    input  logic  queue_full,
    output logic  push,
    output uop_t  uop
);

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    imm_type_t  imm_type;
    logic       supported;
    logic       accept;
    logic       keep;

    // funct3 picks the operation, alt is the funct7[5] variant (sub, sra)
    function automatic alu_func_t f3_alufn(logic [2:0] f3, logic alt);
        alu_func_t fn;
        case (f3)
            3'b000:  fn = alt ? ALU_SUB : ALU_ADD;
            3'b001:  fn = ALU_SLL;
            3'b010:  fn = ALU_SLT;
            3'b011:  fn = ALU_SLTU;
            3'b100:  fn = ALU_XOR;
            3'b101:  fn = alt ? ALU_SRA : ALU_SRL;
            3'b110:  fn = ALU_OR;
            default: fn = ALU_AND;
        endcase
        return fn;
    endfunction

    assign opcode = instr_data[6:0];
    assign rd     = instr_data[11:7];
    assign funct3 = instr_data[14:12];
    assign rs1    = instr_data[19:15];
    assign rs2    = instr_data[24:20];
    assign funct7 = instr_data[31:25];

    always_comb begin
        uop       = '0;
        imm_type  = IMM_I;
        supported = 1'b0;
        uop.rd    = rd;
        uop.rs1   = rs1;
        uop.rs2   = rs2;
        case (opcode)
            OPC_OP_IMM: begin
                supported    = 1'b1;
                // only the shift-right immediate has an alternate form
                uop.alufn    = f3_alufn(funct3, (funct3 == 3'b101) & funct7[5]);
                uop.opr2_sel = OPR2_IMM;
                uop.has_rd   = 1'b1;
                uop.has_rs1  = 1'b1;
            end
            OPC_OP: begin
                supported    = 1'b1;
                uop.alufn    = f3_alufn(funct3, funct7[5]);
                uop.opr2_sel = OPR2_RS2;
                uop.has_rd   = 1'b1;
                uop.has_rs1  = 1'b1;
                uop.has_rs2  = 1'b1;
            end
            OPC_LUI: begin
                supported    = 1'b1;
                uop.alufn    = ALU_ADD;
                uop.opr2_sel = OPR2_IMM;
                uop.is_lui   = 1'b1;
                uop.has_rd   = 1'b1;
                imm_type     = IMM_U;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
        if (imm_type == IMM_U) begin
            uop.imm = {instr_data[31:12], 12'b0};
        end else begin
            uop.imm = {{20{instr_data[31]}}, instr_data[31:20]};
        end
    end

    // new request, not yet acked, and room in the queue
    assign accept = instr_req & ~instr_ack & ~queue_full;

    // x0 targets and foreign opcodes are acked but vanish here
    assign keep = supported & (rd != '0) & (instr_data != `NOP_INSTR);
    assign push = accept & keep;

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_ack <= 1'b0;
        end else if (accept) begin
            instr_ack <= 1'b1;
        end else if (!instr_req) begin
            instr_ack <= 1'b0;
        end
    end

endmodule

// File: hdl/alu_issue_if.sv
// registered micro-op path from the issue stage to the alu stage
interface alu_issue_if
    import core_pkg::*;
();

    logic      valid;
    reg_idx_t  rd;
    alu_func_t alufn;
    word_t     opr1;
    word_t     opr2;

    // issue side owns the issue register
    modport issue_mp (
        output valid,
        output rd,
        output alufn,
        output opr1,
        output opr2
    );

    modport alu_mp (
        input valid,
        input rd,
        input alufn,
        input opr1,
        input opr2
    );

endinterface

// File: hdl/core_pkg.sv
// shared types of the integer core, imported by every stage and the issue interface
`include "core_defs.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // alu operations, encoding is internal to the core
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_func_t;

    // second alu operand source
    typedef enum logic {
        OPR2_RS2 = 1'b0,
        OPR2_IMM = 1'b1
    } opr2_sel_t;

    // immediate formats used by the supported opcodes
    typedef enum logic {
        IMM_I = 1'b0,
        IMM_U = 1'b1
    } imm_type_t;

    // one decoded instruction as it sits in the queue
    typedef struct packed {
        alu_func_t alufn;
        opr2_sel_t opr2_sel;
        logic      is_lui;
        logic      has_rd;
        logic      has_rs1;
        logic      has_rs2;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        // already sign extended or shifted by decode
        word_t     imm;
    } uop_t;

    // result leaving the alu stage
    typedef struct packed {
        logic     has_rd;
        reg_idx_t rd;
        word_t    result;
    } wb_bus_t;

endpackage

// File: hdl/core_defs.svh
// global widths and sizes of the integer core, included by the package and the RTL
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path width
`define XLEN 32

// architectural registers and their index width
`define NUM_REGS 32
`define REG_IDX_W 5

// micro-op entries between decode and issue
`define IQ_DEPTH 8

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
